//--- filelist.f
+incdir+include
design/cam_bist_pkg.sv
design/cam_array_pkg.sv
design/cam_bist_inhandler.sv
design/cam_bist_sequencer.sv
design/cam_port_arbiter.sv
design/cam_array.sv
design/cam_bist_checker.sv
design/cam_bist_top.sv
sim/cam_bist_monitor.sv
sim/cam_bist_tb.sv

//--- sim/cam_bist_stimulus.txt
// Columns: op, addr, retain, exp_fail as one hex digit each, then a and b as four hex digits each
// op 1 write a at addr, 2 fill entry i with a+i*b, 3 search key a expecting match b
// op 4 BIST run expecting fail and fail_step b, op 5 same with a refused functional write
// Functional writes and searches on an address-dependent fill
200010000001
300010050020
190010050000
300010050220
3000100F8000
300012340000
// Normal run leaves the inverted background in every entry
400000000000
30005A5A0000
3000A5A5FFFF
// Retention has no writes, so the inverted pass misses on its first hit compare, step 16
20005A5A0000
401100000010
// One corrupt entry fails the very first hit compare
170011110000
401100000000
// Write and search refused during the run, contents checked afterwards
20005A5A0000
53110F0F0010
30000F0F0000
30005A5AFFFF
000000000000

//--- sim/cam_bist_tb.sv
// Commands come from sim/cam_bist_stimulus.txt, run from the project root; ends at op 0
`default_nettype none
`include "cam_bist_config.svh"

module cam_bist_tb;

   logic                   bist_clk;
   logic                   rst_b;
   logic                   bist_start;
   logic                   retain;
   cam_array_pkg::access_t func_access;
   logic [`CAM_ADDR_W-1:0] func_addr;
   logic [`CAM_WIDTH-1:0]  func_wdata;
   logic [`CAM_WIDTH-1:0]  func_key;
   logic                   func_gnt;
   logic [`CAM_DEPTH-1:0]  match;
   logic                   match_valid;
   logic                   bist_busy;
   logic                   done;
   logic                   fail;
   logic [`CAM_STEP_W-1:0] fail_step;
   // Expectations handed to the monitor
   logic                   match_chk;
   logic [`CAM_DEPTH-1:0]  exp_match;
   logic                   exp_fail;
   logic [`CAM_STEP_W-1:0] exp_step;
   logic                   report;
   int                     error_count;
   // op, addr, retain, exp_fail, a, b
   logic [47:0]            cmds [64];
   int                     n_cmds;
   int                     cycle_limit;
   int                     cycle_count;
   int                     tb_errors;

   cam_bist_top dut0 (
      .bist_clk (bist_clk), .rst_b (rst_b), .bist_start (bist_start), .retain (retain),
      .func_access (func_access), .func_addr (func_addr), .func_wdata (func_wdata),
      .func_key (func_key), .func_gnt (func_gnt), .match (match),
      .match_valid (match_valid), .bist_busy (bist_busy), .done (done), .fail (fail),
      .fail_step (fail_step)
   );

   // Grant register is read straight from the arbiter inside the DUT
   cam_bist_monitor mon0 (
      .bist_clk (bist_clk), .rst_b (rst_b), .bist_start (bist_start), .retain (retain),
      .func_access (func_access), .func_gnt (func_gnt), .owner (dut0.owner),
      .match (match), .match_valid (match_valid), .bist_busy (bist_busy), .done (done),
      .fail (fail), .fail_step (fail_step), .match_chk (match_chk), .exp_match (exp_match),
      .exp_fail (exp_fail), .exp_step (exp_step), .report (report),
      .error_count (error_count)
   );

   initial begin
      bist_clk = 1'b0;
      forever #5 bist_clk = ~bist_clk;
   end

   // Run ends at the limit worked out from the stimulus
   always @(posedge bist_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout: test did not finish within %0d cycles", cycle_limit);
         $display("Done: errors found");
         $finish;
      end
   end

   //----------------------------------------------------------------------
   // Command lengths and drivers
   //----------------------------------------------------------------------
   function automatic int bist_cycles(input logic r);
      return `CAM_BIST_PASSES * (2 * `CAM_WIDTH + (r ? 0 : `CAM_DEPTH)) + 2;
   endfunction

   function automatic int command_cycles(input logic [47:0] cmd);
      case (cmd[47:44])
         4'h1: return 2;
         4'h2: return `CAM_DEPTH + 1;
         4'h3: return 3;
         4'h4, 4'h5: return bist_cycles(cmd[39:36] != 4'h0) + 4;
         default: return 1;
      endcase
   endfunction

   task automatic write_entry(input logic [`CAM_ADDR_W-1:0] addr,
                              input logic [`CAM_WIDTH-1:0] data);
      @(posedge bist_clk);
      func_access <= cam_array_pkg::acc_write;
      func_addr   <= addr;
      func_wdata  <= data;
   endtask

   task automatic release_port();
      @(posedge bist_clk);
      func_access <= cam_array_pkg::acc_idle;
   endtask

   // Match is checked by the monitor two edges after the search is driven
   task automatic search_key(input logic [`CAM_WIDTH-1:0] key,
                             input logic [`CAM_DEPTH-1:0] expected);
      @(posedge bist_clk);
      func_access <= cam_array_pkg::acc_search;
      func_key    <= key;
      @(posedge bist_clk);
      func_access <= cam_array_pkg::acc_idle;
      match_chk   <= 1'b1;
      exp_match   <= expected;
      @(posedge bist_clk);
      match_chk   <= 1'b0;
   endtask

   task automatic run_bist(input logic r, input logic ef, input logic [`CAM_STEP_W-1:0] st,
                           input logic with_func, input logic [`CAM_ADDR_W-1:0] addr,
                           input logic [`CAM_WIDTH-1:0] data);
      @(posedge bist_clk);
      bist_start <= 1'b1;
      retain     <= r;
      exp_fail   <= ef;
      exp_step   <= st;
      @(posedge bist_clk);
      bist_start <= 1'b0;
      // Write then search in mid run, both must be dropped
      if (with_func) begin
         repeat (8) @(posedge bist_clk);
         write_entry(addr, data);
         @(posedge bist_clk);
         func_access <= cam_array_pkg::acc_search;
         func_key    <= data;
         release_port();
      end
      do @(posedge bist_clk); while (done !== 1'b1);
      retain <= 1'b0;
   endtask

   task automatic run_command(input logic [47:0] cmd);
      logic [3:0]             op;
      logic [`CAM_ADDR_W-1:0] addr;
      logic [`CAM_WIDTH-1:0]  a;
      logic [`CAM_WIDTH-1:0]  b;
      op   = cmd[47:44];
      addr = cmd[40 +: `CAM_ADDR_W];
      a    = cmd[31:16];
      b    = cmd[15:0];
      case (op)
         4'h1: begin
            write_entry(addr, a);
            release_port();
         end
         4'h2: begin
            for (int i = 0; i < `CAM_DEPTH; i++) begin
               write_entry(`CAM_ADDR_W'(i), `CAM_WIDTH'(a + i * b));
            end
            release_port();
         end
         4'h3: search_key(a, b[`CAM_DEPTH-1:0]);
         4'h4, 4'h5: begin
            run_bist(cmd[39:36] != 4'h0, cmd[35:32] != 4'h0, b[`CAM_STEP_W-1:0],
                     op == 4'h5, addr, a);
         end
         default: begin
            tb_errors++;
            $display("unknown command %h in the stimulus file", cmd);
         end
      endcase
   endtask

   //----------------------------------------------------------------------
   // Main sequence
   //----------------------------------------------------------------------
   initial begin
      rst_b       = 1'b0;
      bist_start  = 1'b0;
      retain      = 1'b0;
      func_access = cam_array_pkg::acc_idle;
      func_addr   = '0;
      func_wdata  = '0;
      func_key    = '0;
      match_chk   = 1'b0;
      exp_match   = '0;
      exp_fail    = 1'b0;
      exp_step    = '0;
      report      = 1'b0;
      cycle_count = 0;
      tb_errors   = 0;
      $readmemh("sim/cam_bist_stimulus.txt", cmds);
      // Reset, end of test and margin
      cycle_limit = 4 + 3 + 50;
      n_cmds      = 0;
      while (n_cmds < 64 && !$isunknown(cmds[n_cmds]) && cmds[n_cmds][47:44] != 4'h0) begin
         cycle_limit += command_cycles(cmds[n_cmds]);
         n_cmds++;
      end
      if (n_cmds == 0) begin
         tb_errors++;
         $display("stimulus file holds no commands");
      end
      repeat (4) @(posedge bist_clk);
      rst_b <= 1'b1;
      for (int i = 0; i < n_cmds; i++) begin
         run_command(cmds[i]);
      end
      @(posedge bist_clk);
      report <= 1'b1;
      @(posedge bist_clk);
      report <= 1'b0;
      // Monitor has printed its closing line by now
      @(negedge bist_clk);
      if (error_count == 0 && tb_errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/cam_bist_monitor.sv
// Expects one BIST run at a time; run length is derived from the config sizes, not from the DUT
`default_nettype none
`include "cam_bist_config.svh"

module cam_bist_monitor (
   input  wire logic                   bist_clk,
   input  wire logic                   rst_b,
   input  wire logic                   bist_start,
   input  wire logic                   retain,
   input  wire cam_array_pkg::access_t func_access,
   input  wire logic                   func_gnt,
   input  wire cam_array_pkg::owner_t  owner,
   input  wire logic [`CAM_DEPTH-1:0]  match,
   input  wire logic                   match_valid,
   input  wire logic                   bist_busy,
   input  wire logic                   done,
   input  wire logic                   fail,
   input  wire logic [`CAM_STEP_W-1:0] fail_step,
   input  wire logic                   match_chk,
   input  wire logic [`CAM_DEPTH-1:0]  exp_match,
   input  wire logic                   exp_fail,
   input  wire logic [`CAM_STEP_W-1:0] exp_step,
   input  wire logic                   report,
   output int                          error_count
);

   int   errors;
   int   checks;
   int   elapsed;
   int   run_len;
   logic running;
   logic reset_seen;

   initial begin
      errors     = 0;
      checks     = 0;
      elapsed    = 0;
      run_len    = 0;
      running    = 1'b0;
      reset_seen = 1'b0;
   end

   assign error_count = errors;

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   //----------------------------------------------------------------------
   // Sampling at each rising edge
   //----------------------------------------------------------------------
   always @(posedge bist_clk) begin
      if (rst_b) begin
         // First cycle out of reset
         if (!reset_seen) begin
            reset_seen = 1'b1;
            check_value("bist_busy", 0, bist_busy);
            check_value("done", 0, done);
            check_value("fail", 0, fail);
            check_value("match_valid", 0, match_valid);
            check_value("func_gnt", 0, func_gnt);
         end
         // Refused for the whole run, otherwise granted for any request
         check_value("func_gnt", !running && (func_access != cam_array_pkg::acc_idle), func_gnt);
         if (!running) begin
            check_value("match_valid", match_chk, match_valid);
            check_value("bist_busy", 0, bist_busy);
            check_value("done", 0, done);
            check_value("owner", cam_array_pkg::own_func, owner);
            if (match_chk) begin
               check_value("match", exp_match, match);
            end
            // Start edge, counting begins here
            if (bist_start) begin
               running = 1'b1;
               elapsed = 0;
               // Writes per pass only without retention, two compares per bit, two drain cycles
               run_len = `CAM_BIST_PASSES * (2 * `CAM_WIDTH + (retain ? 0 : `CAM_DEPTH)) + 2;
            end
         end else begin
            elapsed++;
            // Grant register takes the port one cycle after busy rises
            if (elapsed > 1) begin
               check_value("owner", cam_array_pkg::own_bist, owner);
            end
            if (elapsed <= run_len) begin
               check_value("bist_busy", 1, bist_busy);
               check_value("done", 0, done);
            end else begin
               // Done cycle, status is final
               check_value("done", 1, done);
               check_value("bist_busy", 0, bist_busy);
               check_value("fail", exp_fail, fail);
               if (exp_fail) begin
                  check_value("fail_step", exp_step, fail_step);
               end
               running = 1'b0;
            end
         end
         if (report) begin
            if (running) begin
               errors++;
               $display("BIST run still active when the test ended");
            end
            $display("monitor: %0d checks, %0d errors", checks, errors);
         end
      end
   end

endmodule

`default_nettype wire

//--- design/cam_bist_top.sv
// Single CAM port shared by BIST and functional peers; functional access is refused during a run
`default_nettype none
`include "cam_bist_config.svh"

module cam_bist_top (
   input  wire logic                   bist_clk,
   input  wire logic                   rst_b,
   input  wire logic                   bist_start,
   input  wire logic                   retain,
   input  cam_array_pkg::access_t      func_access,
   input  wire logic [`CAM_ADDR_W-1:0] func_addr,
   input  wire logic [`CAM_WIDTH-1:0]  func_wdata,
   input  wire logic [`CAM_WIDTH-1:0]  func_key,
   output logic                        func_gnt,
   output logic      [`CAM_DEPTH-1:0]  match,
   output logic                        match_valid,
   output logic                        bist_busy,
   output logic                        done,
   output logic                        fail,
   output logic      [`CAM_STEP_W-1:0] fail_step
);

   //----------------------------------------------------------------------
   // Internal nets
   //----------------------------------------------------------------------
   // Sequencer to handler
   logic                   mask_en;
   logic                   rotate_mask;
   logic                   data_inv;
   logic [`CAM_WIDTH-1:0]  background;
   // Handler to arbiter
   logic [`CAM_WIDTH-1:0]  wr_data;
   logic [`CAM_WIDTH-1:0]  cm_data;
   // BIST request
   cam_array_pkg::access_t bist_access;
   logic [`CAM_ADDR_W-1:0] bist_addr;
   cam_bist_pkg::bist_op_t bist_op;
   logic [`CAM_STEP_W-1:0] step;
   // Arbiter to array and checker
   cam_array_pkg::access_t arr_access;
   logic [`CAM_ADDR_W-1:0] arr_addr;
   logic [`CAM_WIDTH-1:0]  arr_wdata;
   logic [`CAM_WIDTH-1:0]  arr_key;
   cam_bist_pkg::bist_op_t arr_op;
   // Current grant, observed by the testbench
   cam_array_pkg::owner_t  owner;

   cam_bist_sequencer u_seq (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .bist_start  (bist_start),
      .retain      (retain),
      .mask_en     (mask_en),
      .rotate_mask (rotate_mask),
      .data_inv    (data_inv),
      .background  (background),
      .bist_access (bist_access),
      .bist_addr   (bist_addr),
      .bist_op     (bist_op),
      .bist_busy   (bist_busy),
      .done        (done),
      .step        (step)
   );

   cam_bist_inhandler u_inh (
      .bist_clk     (bist_clk),
      .rst_b        (rst_b),
      .rotate_mask  (rotate_mask),
      .mask_en      (mask_en),
      .data_inv     (data_inv),
      .bist_wr_data (background),
      .wr_data      (wr_data),
      .cm_data      (cm_data)
   );

   // BIST writes the background and searches with the compare data
   cam_port_arbiter u_arb (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .bist_busy   (bist_busy),
      .bist_access (bist_access),
      .bist_addr   (bist_addr),
      .bist_wdata  (wr_data),
      .bist_key    (cm_data),
      .bist_op     (bist_op),
      .func_access (func_access),
      .func_addr   (func_addr),
      .func_wdata  (func_wdata),
      .func_key    (func_key),
      .func_gnt    (func_gnt),
      .arr_access  (arr_access),
      .arr_addr    (arr_addr),
      .arr_wdata   (arr_wdata),
      .arr_key     (arr_key),
      .arr_op      (arr_op),
      .owner       (owner)
   );

   cam_array u_arr (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .access      (arr_access),
      .addr        (arr_addr),
      .wdata       (arr_wdata),
      .key         (arr_key),
      .match       (match),
      .match_valid (match_valid)
   );

   cam_bist_checker u_chk (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .bist_start  (bist_start),
      .arr_op      (arr_op),
      .step        (step),
      .match       (match),
      .match_valid (match_valid),
      .fail        (fail),
      .fail_step   (fail_step)
   );

endmodule

`default_nettype wire

//--- design/cam_bist_checker.sv
// Only the first failing step is kept; status clears on bist_start and nowhere else
`default_nettype none
`include "cam_bist_config.svh"

module cam_bist_checker (
   input  wire logic                   bist_clk,
   input  wire logic                   rst_b,
   input  wire logic                   bist_start,
   input  cam_bist_pkg::bist_op_t      arr_op,
   input  wire logic [`CAM_STEP_W-1:0] step,
   input  wire logic [`CAM_DEPTH-1:0]  match,
   input  wire logic                   match_valid,
   output logic                        fail,
   output logic      [`CAM_STEP_W-1:0] fail_step
);

   // Op and step delayed to line up with match
   cam_bist_pkg::bist_op_t op_q;
   logic [`CAM_STEP_W-1:0] step_q;
   logic [`CAM_DEPTH-1:0]  expected;
   logic                   mismatch;

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         op_q <= cam_bist_pkg::op_none;
      end else begin
         op_q <= arr_op;
      end
   end

   always_ff @(posedge bist_clk) begin
      step_q <= step;
   end

   // Hit expects every entry, miss expects none
   assign expected = (op_q == cam_bist_pkg::op_hit) ? {`CAM_DEPTH{1'b1}} : '0;

   assign mismatch = match_valid && (op_q != cam_bist_pkg::op_none) && (match != expected);

   //----------------------------------------------------------------------
   // Sticky status
   //----------------------------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         fail      <= 1'b0;
         fail_step <= '0;
      end else if (bist_start) begin
         fail      <= 1'b0;
         fail_step <= '0;
      end else if (mismatch && !fail) begin
         fail      <= 1'b1;
         fail_step <= step_q;
      end
   end

endmodule

`default_nettype wire

//--- design/cam_array.sv
// Behavioral model with no storage reset; contents are unknown until written
`default_nettype none
`include "cam_bist_config.svh"

module cam_array (
   input  wire logic                   bist_clk,
   input  wire logic                   rst_b,
   input  cam_array_pkg::access_t      access,
   input  wire logic [`CAM_ADDR_W-1:0] addr,
   input  wire logic [`CAM_WIDTH-1:0]  wdata,
   input  wire logic [`CAM_WIDTH-1:0]  key,
   output logic      [`CAM_DEPTH-1:0]  match,
   output logic                        match_valid
);

   logic [`CAM_WIDTH-1:0] mem [`CAM_DEPTH];

   //----------------------------------------------------------------------
   // Storage
   //----------------------------------------------------------------------
   // Write lands at the edge of the access cycle
   always_ff @(posedge bist_clk) begin
      if (access == cam_array_pkg::acc_write) begin
         mem[addr] <= wdata;
      end
   end

   //----------------------------------------------------------------------
   // Search
   //----------------------------------------------------------------------
   // Key against every entry in parallel
   // Bit i of match set when entry i equals the key
   always_ff @(posedge bist_clk) begin
      if (access == cam_array_pkg::acc_search) begin
         for (int i = 0; i < `CAM_DEPTH; i++) begin
            match[i] <= (mem[i] == key);
         end
      end
   end

   // Valid one cycle after the search cycle
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         match_valid <= 1'b0;
      end else begin
         match_valid <= (access == cam_array_pkg::acc_search);
      end
   end

endmodule

`default_nettype wire

//--- design/cam_port_arbiter.sv
// BIST has priority for a whole run; functional requests are dropped, never queued
`default_nettype none
`include "cam_bist_config.svh"

module cam_port_arbiter (
   input  wire logic                   bist_clk,
   input  wire logic                   rst_b,
   input  wire logic                   bist_busy,
   input  cam_array_pkg::access_t      bist_access,
   input  wire logic [`CAM_ADDR_W-1:0] bist_addr,
   input  wire logic [`CAM_WIDTH-1:0]  bist_wdata,
   input  wire logic [`CAM_WIDTH-1:0]  bist_key,
   input  cam_bist_pkg::bist_op_t      bist_op,
   input  cam_array_pkg::access_t      func_access,
   input  wire logic [`CAM_ADDR_W-1:0] func_addr,
   input  wire logic [`CAM_WIDTH-1:0]  func_wdata,
   input  wire logic [`CAM_WIDTH-1:0]  func_key,
   output logic                        func_gnt,
   output cam_array_pkg::access_t      arr_access,
   output logic      [`CAM_ADDR_W-1:0] arr_addr,
   output logic      [`CAM_WIDTH-1:0]  arr_wdata,
   output logic      [`CAM_WIDTH-1:0]  arr_key,
   output cam_bist_pkg::bist_op_t      arr_op,
   output cam_array_pkg::owner_t       owner
);

   logic bist_sel;

   // Grant register follows bist_busy
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         owner <= cam_array_pkg::own_func;
      end else begin
         owner <= bist_busy ? cam_array_pkg::own_bist : cam_array_pkg::own_func;
      end
   end

   // Busy takes the port in its first cycle
   // The owner register keeps it one more cycle, through the done cycle
   assign bist_sel = bist_busy || (owner == cam_array_pkg::own_bist);

   //----------------------------------------------------------------------
   // Request mux
   //----------------------------------------------------------------------
   always_comb begin
      if (bist_sel) begin
         arr_access = bist_access;
         arr_addr   = bist_addr;
         arr_wdata  = bist_wdata;
         arr_key    = bist_key;
         arr_op     = bist_op;
      end else begin
         arr_access = func_access;
         arr_addr   = func_addr;
         arr_wdata  = func_wdata;
         arr_key    = func_key;
         // Functional searches are never checked
         arr_op     = cam_bist_pkg::op_none;
      end
   end

   // Grant only for a real functional request that reaches the array
   assign func_gnt = !bist_sel && (func_access != cam_array_pkg::acc_idle);

endmodule

`default_nettype wire

//--- design/cam_bist_sequencer.sv
// One run per bist_start pulse taken in idle only; retain is sampled at start and skips all writes
`default_nettype none
`include "cam_bist_config.svh"

module cam_bist_sequencer (
   input  wire logic                        bist_clk,
   input  wire logic                        rst_b,
   input  wire logic                        bist_start,
   input  wire logic                        retain,
   output logic                             mask_en,
   output logic                             rotate_mask,
   output logic                             data_inv,
   output logic      [`CAM_WIDTH-1:0]       background,
   output cam_array_pkg::access_t           bist_access,
   output logic      [`CAM_ADDR_W-1:0]      bist_addr,
   output cam_bist_pkg::bist_op_t           bist_op,
   output logic                             bist_busy,
   output logic                             done,
   output logic      [`CAM_STEP_W-1:0]      step
);

   localparam int BIT_W  = $clog2(`CAM_WIDTH);
   localparam int PASS_W = `CAM_STEP_W - BIT_W;

   // Alternating checkerboard background
   localparam logic [`CAM_WIDTH-1:0] BACKGROUND = {(`CAM_WIDTH/16){16'h5A5A}};

   cam_bist_pkg::seq_state_t state;

   // Entry counter, also counts the two drain cycles
   logic [`CAM_ADDR_W-1:0] addr_q;
   // Mask position within the pass
   logic [BIT_W-1:0]       bit_q;
   logic [PASS_W-1:0]      pass_q;
   logic                   retain_q;

   logic last_addr;
   logic last_bit;
   logic last_pass;

   assign last_addr = (addr_q == `CAM_ADDR_W'(`CAM_DEPTH - 1));
   assign last_bit  = (bit_q == BIT_W'(`CAM_WIDTH - 1));
   assign last_pass = (pass_q == PASS_W'(`CAM_BIST_PASSES - 1));

   //----------------------------------------------------------------------
   // State and counters
   //----------------------------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         state    <= cam_bist_pkg::idle;
         addr_q   <= '0;
         bit_q    <= '0;
         pass_q   <= '0;
         retain_q <= 1'b0;
      end else begin
         case (state)
            cam_bist_pkg::idle: begin
               if (bist_start) begin
                  addr_q   <= '0;
                  bit_q    <= '0;
                  pass_q   <= '0;
                  retain_q <= retain;
                  state    <= retain ? cam_bist_pkg::compare_hit : cam_bist_pkg::write;
               end
            end
            // One entry per cycle, counter wraps to 0 after the last one
            cam_bist_pkg::write: begin
               addr_q <= addr_q + 1'b1;
               if (last_addr) begin
                  state <= cam_bist_pkg::compare_hit;
               end
            end
            cam_bist_pkg::compare_hit: begin
               state <= cam_bist_pkg::compare_miss;
            end
            // Pair finished, mask rotates at this edge
            cam_bist_pkg::compare_miss: begin
               bit_q <= bit_q + 1'b1;
               if (!last_bit) begin
                  state <= cam_bist_pkg::compare_hit;
               end else if (last_pass) begin
                  state <= cam_bist_pkg::drain;
               end else begin
                  pass_q <= pass_q + 1'b1;
                  state  <= retain_q ? cam_bist_pkg::compare_hit : cam_bist_pkg::write;
               end
            end
            // Two cycles so the last match vector reaches the checker
            cam_bist_pkg::drain: begin
               addr_q <= addr_q + 1'b1;
               if (addr_q == `CAM_ADDR_W'(1)) begin
                  addr_q <= '0;
                  state  <= cam_bist_pkg::done;
               end
            end
            cam_bist_pkg::done: begin
               state <= cam_bist_pkg::idle;
            end
            default: begin
               state <= cam_bist_pkg::idle;
            end
         endcase
      end
   end

   //----------------------------------------------------------------------
   // Operation decode
   //----------------------------------------------------------------------
   always_comb begin
      bist_access = cam_array_pkg::acc_idle;
      bist_op     = cam_bist_pkg::op_none;
      mask_en     = 1'b0;
      rotate_mask = 1'b0;
      case (state)
         cam_bist_pkg::write: begin
            bist_access = cam_array_pkg::acc_write;
         end
         cam_bist_pkg::compare_hit: begin
            bist_access = cam_array_pkg::acc_search;
            bist_op     = cam_bist_pkg::op_hit;
         end
         cam_bist_pkg::compare_miss: begin
            bist_access = cam_array_pkg::acc_search;
            bist_op     = cam_bist_pkg::op_miss;
            mask_en     = 1'b1;
            rotate_mask = 1'b1;
         end
         default: begin
            bist_access = cam_array_pkg::acc_idle;
         end
      endcase
   end

   assign bist_addr  = addr_q;
   // Odd passes use the inverted background
   assign data_inv   = pass_q[0];
   assign background = BACKGROUND;
   // Busy from the first operation through drain, low in the done cycle
   assign bist_busy  = (state != cam_bist_pkg::idle) && (state != cam_bist_pkg::done);
   assign done       = (state == cam_bist_pkg::done);
   assign step       = {pass_q, bit_q};

endmodule

`default_nettype wire

//--- design/cam_bist_inhandler.sv
// Mask and data paths for BIST only; wr_data and cm_data are combinational from the controls
`default_nettype none
`include "cam_bist_config.svh"

module cam_bist_inhandler (
   input  wire logic                  bist_clk,
   input  wire logic                  rst_b,
   input  wire logic                  rotate_mask,
   input  wire logic                  mask_en,
   input  wire logic                  data_inv,
   input  wire logic [`CAM_WIDTH-1:0] bist_wr_data,
   output logic      [`CAM_WIDTH-1:0] wr_data,
   output logic      [`CAM_WIDTH-1:0] cm_data
);

   // One-hot walking mask
   logic [`CAM_WIDTH-1:0] mask;

   //----------------------------------------------------------------------
   // Rotating mask
   //----------------------------------------------------------------------
   // Starts at bit 0 and moves up one place per pulse
   // Top bit wraps back to bit 0, so a full pass returns it home
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         mask <= {{(`CAM_WIDTH-1){1'b0}}, 1'b1};
      end else if (rotate_mask) begin
         mask <= {mask[`CAM_WIDTH-2:0], mask[`CAM_WIDTH-1]};
      end
   end

   //----------------------------------------------------------------------
   // Data generation
   //----------------------------------------------------------------------
   // Background as written, inverted in the second pass
   assign wr_data = bist_wr_data ^ {`CAM_WIDTH{data_inv}};

   // Compare data equals stored data unless the mask is enabled
   // With the mask on, exactly one bit differs so every entry misses
   assign cm_data = wr_data ^ (mask & {`CAM_WIDTH{mask_en}});

endmodule

`default_nettype wire

//--- design/cam_array_pkg.sv
// Array access types shared by the arbiter, the array and the testbench
`default_nettype none

package cam_array_pkg;

   // One access per cycle on the single port
   typedef enum logic [1:0] {
      acc_idle   = 2'd0,
      acc_write  = 2'd1,
      acc_search = 2'd2
   } access_t;

   // Current owner of the array port
   typedef enum logic {
      own_func = 1'b0,
      own_bist = 1'b1
   } owner_t;

endpackage

`default_nettype wire

//--- design/cam_bist_pkg.sv
// Test algorithm types only and independent of array size
`default_nettype none

package cam_bist_pkg;

   // Sequencer states
   // Writes are skipped in retention mode
   typedef enum logic [2:0] {
      idle         = 3'd0,
      write        = 3'd1,
      compare_hit  = 3'd2,
      compare_miss = 3'd3,
      drain        = 3'd4,
      done         = 3'd5
   } seq_state_t;

   // Kind of BIST search, tells the checker what match vector to expect
   typedef enum logic [1:0] {
      // Functional access or no search
      op_none = 2'd0,
      // Unmasked key, all entries must match
      op_hit  = 2'd1,
      // One bit flipped, no entry may match
      op_miss = 2'd2
   } bist_op_t;

endpackage

`default_nettype wire

//--- include/cam_bist_config.svh
// Sizes are fixed for the whole subsystem and CAM_STEP_W must cover passes times word width
`ifndef CAM_BIST_CONFIG_SVH
`define CAM_BIST_CONFIG_SVH

//----------------------------------------------------------------------
// Array geometry
//----------------------------------------------------------------------
// Number of CAM entries
`define CAM_DEPTH 16
// Entry width in bits, also the number of mask positions per pass
`define CAM_WIDTH 16
// Address width for CAM_DEPTH entries
`define CAM_ADDR_W 4

//----------------------------------------------------------------------
// Test algorithm
//----------------------------------------------------------------------
// Plain pass then inverted pass
`define CAM_BIST_PASSES 2
// Step index covers compare pairs over all passes, 2 x 16 = 32
`define CAM_STEP_W 5

`endif
